/* verilog/opl3_pkg.sv */
`default_nettype none

package opl3_pkg;

    //////////////////////////////////////////////////////////////////////
    // Slot layout of the time-multiplexed operator array.
    //////////////////////////////////////////////////////////////////////
    localparam int BANK_NUM_WIDTH = 1;         // Two banks.
    localparam int OP_NUM_WIDTH = 5;           // Operator number within a bank.
    localparam int NUM_OPS_PER_BANK = 18;
    localparam int NUM_SLOTS = 36;             // Both banks, walked once per sample.
    localparam int SLOT_WIDTH = 6;             // Flat slot index, 0 to 35.

    //////////////////////////////////////////////////////////////////////
    // Register field widths and envelope limits.
    //////////////////////////////////////////////////////////////////////
    localparam int REG_FNUM_WIDTH = 10;
    localparam int REG_BLOCK_WIDTH = 3;
    localparam int REG_ENV_WIDTH = 4;          // Requested rate, 0 to 15.
    localparam int ENV_SHIFT_WIDTH = 2;        // Per-sample step, 0 to 3.
    localparam int ENV_LEVEL_WIDTH = 9;
    localparam int ENV_LEVEL_MAX = 511;        // Full attenuation.

    // Envelope parameters of one operator slot.
    typedef struct packed {
        logic ksr;                             // Key scale rate.
        logic nts;                             // Keyboard split selection.
        logic [REG_FNUM_WIDTH-1:0] fnum;
        logic [REG_BLOCK_WIDTH-1:0] block;
        logic [REG_ENV_WIDTH-1:0] rate;        // Requested rate.
    } op_env_params_t;

    // One host write: the target slot and its new parameters.
    typedef struct packed {
        logic [SLOT_WIDTH-1:0] slot;
        op_env_params_t params;
    } slot_write_t;

endpackage

`default_nettype wire

/* verilog/pipeline_sr.sv */
`default_nettype none

// Plain delay line. Every stage is brought out so the caller can tap
// whichever cycle it needs.
module pipeline_sr #(
    parameter type payload_t = logic,
    parameter int ENDING_CYCLE = 1
) (
    input wire clk,
    input wire payload_t in,
    output payload_t out [1:ENDING_CYCLE]
);

    always_ff @(posedge clk) begin
        out[1] <= in;                          // First stage takes the input.
        for (int i = 2; i <= ENDING_CYCLE; i++) begin
            out[i] <= out[i-1];                // The rest shift along.
        end
    end

endmodule

`default_nettype wire

/* verilog/op_sequencer.sv */
`default_nettype none

// Walks bank 0 operators 0 to 17, then bank 1 operators 0 to 17, at the
// start of every sample period. The remaining cycles of the period are idle.
module op_sequencer
    import opl3_pkg::*;
#(
    parameter int CLKS_PER_SAMPLE = 40
) (
    input wire clk,
    input wire reset,
    output logic sample_clk_en,
    output logic [BANK_NUM_WIDTH-1:0] bank_num,
    output logic [OP_NUM_WIDTH-1:0] op_num
);

    localparam int CNT_WIDTH = $clog2(CLKS_PER_SAMPLE);

    logic [CNT_WIDTH-1:0] cycle_cnt;           // Position within the sample period.

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_cnt <= '0;
            sample_clk_en <= 1'b0;
            bank_num <= '0;
            op_num <= '0;
        end else begin
            if (cycle_cnt == CNT_WIDTH'(CLKS_PER_SAMPLE - 1))
                cycle_cnt <= '0;               // Wrap to the next sample.
            else
                cycle_cnt <= cycle_cnt + 1'b1;

            // Outputs are registered, so they trail the counter by one cycle.
            sample_clk_en <= cycle_cnt < NUM_SLOTS;

            if (cycle_cnt < NUM_OPS_PER_BANK) begin
                bank_num <= '0;
                op_num <= OP_NUM_WIDTH'(cycle_cnt);
            end else if (cycle_cnt < NUM_SLOTS) begin
                bank_num <= '1;                // Second bank.
                op_num <= OP_NUM_WIDTH'(cycle_cnt - NUM_OPS_PER_BANK);
            end else begin
                // Idle tail of the period.
                bank_num <= '0;
                op_num <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/op_param_ram.sv */
`default_nettype none

// Envelope parameter store, one entry per operator slot.
module op_param_ram
    import opl3_pkg::*;
(
    input wire clk,
    input wire reset,
    input wire wr_en,
    input wire slot_write_t wr,
    input wire [SLOT_WIDTH-1:0] rd_slot,
    output op_env_params_t params
);

    op_env_params_t entries [NUM_SLOTS];

    // A cleared entry has rate 0, so a slot that was never written stays idle.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                entries[i] <= '0;
            end
        end else if (wr_en) begin
            entries[wr.slot] <= wr.params;     // Single-cycle host write.
        end
    end

    // Combinational read for pipeline stage 0.
    assign params = entries[rd_slot];

endmodule

`default_nettype wire

/* verilog/env_rate_counter.sv */
`default_nettype none

// Turns the slot's parameters into an effective rate and decides the
// attenuation step for this sample. Stage 0 is the parameter read, stage 1
// holds the raw rate, stage 2 holds the result.
module env_rate_counter
    import opl3_pkg::*;
(
    input wire clk,
    input wire reset,
    input wire sample_clk_en,
    input wire [BANK_NUM_WIDTH-1:0] bank_num,
    input wire [OP_NUM_WIDTH-1:0] op_num,
    input wire op_env_params_t params,
    output logic [REG_ENV_WIDTH:0] rate_hi_p2,
    output logic [ENV_SHIFT_WIDTH-1:0] env_shift_p2
);

    localparam int EG_TIMER_WIDTH = 13;
    localparam int PIPELINE_DELAY = 3;
    localparam int EG_ADD_WIDTH = $clog2(EG_TIMER_WIDTH);
    localparam int RATE_WIDTH = REG_ENV_WIDTH + 3;
    // Increment pattern over four samples, indexed by the low rate bits.
    localparam logic [3:0] EG_INC_STEP [4] = '{4'b0000, 4'b1000, 4'b1010, 4'b1110};

    // Returns one plus the index of the lowest set bit, or 0 for no bits.
    function automatic logic [EG_ADD_WIDTH-1:0] lowest_set_pos(
        input logic [EG_TIMER_WIDTH-1:0] t
    );
        logic [EG_ADD_WIDTH-1:0] pos;
        pos = '0;
        for (int i = EG_TIMER_WIDTH - 1; i >= 0; i--) begin
            if (t[i])
                pos = EG_ADD_WIDTH'(i + 1);
        end
        return pos;
    endfunction

    logic [EG_TIMER_WIDTH-1:0] eg_timer;
    logic eg_timerrem;                         // Set after the timer wraps.
    logic eg_state;                            // Toggles every sample.
    logic [EG_ADD_WIDTH-1:0] eg_add;
    logic [1:0] step_cnt;                      // Column of the step table.
    logic [REG_BLOCK_WIDTH:0] ksv_p0;
    logic [REG_BLOCK_WIDTH:0] ks_p0;
    logic [RATE_WIDTH-1:0] rate_p1;
    logic rate_not_zero_p1;
    logic [REG_ENV_WIDTH:0] rate_hi_pre_p1;
    logic [REG_ENV_WIDTH:0] rate_hi_p1;
    logic [1:0] rate_lo_p1;
    logic [REG_ENV_WIDTH+1:0] eg_shift_p1;
    logic [ENV_SHIFT_WIDTH:0] env_shift_pre_p1; // One spare bit for saturation.
    logic en_p [1:PIPELINE_DELAY];
    logic [BANK_NUM_WIDTH-1:0] bank_p [1:PIPELINE_DELAY];
    logic [OP_NUM_WIDTH-1:0] op_p [1:PIPELINE_DELAY];

    pipeline_sr #(.ENDING_CYCLE(PIPELINE_DELAY)) en_sr (
        .clk,
        .in(sample_clk_en),
        .out(en_p)
    );

    pipeline_sr #(
        .payload_t(logic [BANK_NUM_WIDTH-1:0]),
        .ENDING_CYCLE(PIPELINE_DELAY)
    ) bank_sr (
        .clk,
        .in(bank_num),
        .out(bank_p)
    );

    pipeline_sr #(
        .payload_t(logic [OP_NUM_WIDTH-1:0]),
        .ENDING_CYCLE(PIPELINE_DELAY)
    ) op_sr (
        .clk,
        .in(op_num),
        .out(op_p)
    );

    //////////////////////////////////////////////////////////////////////
    // Stage 0 to 1: key scaling and raw rate.
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        // Block times two, low bit from the keyboard split.
        ksv_p0 = {params.block, 1'b0} | {3'b000, params.nts ? params.fnum[8] : params.fnum[9]};
        ks_p0 = params.ksr ? ksv_p0 : ksv_p0 >> 2;
    end

    always_ff @(posedge clk) begin
        rate_p1 <= {3'b000, ks_p0} + {1'b0, params.rate, 2'b00};
        rate_not_zero_p1 <= params.rate != '0;
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 1 to 2: clamp and step selection.
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        rate_hi_pre_p1 = rate_p1[RATE_WIDTH-1:2];
        rate_hi_p1 = (rate_hi_pre_p1 > 15) ? 5'd15 : rate_hi_pre_p1; // Highest rate is 15.
        rate_lo_p1 = rate_p1[1:0];
        eg_shift_p1 = {1'b0, rate_hi_p1} + {2'b00, eg_add};
        env_shift_pre_p1 = {1'b0, rate_hi_p1[1:0]} + {2'b00, EG_INC_STEP[rate_lo_p1][step_cnt]};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rate_hi_p2 <= '0;
            env_shift_p2 <= '0;
        end else begin
            rate_hi_p2 <= rate_hi_p1;
            env_shift_p2 <= '0;                // No step unless a rule below applies.
            if (rate_not_zero_p1) begin
                if (rate_hi_p1 < 12) begin
                    // Slow rates only move on odd samples, at eg_add positions.
                    if (eg_state) begin
                        case (eg_shift_p1)
                            12: env_shift_p2 <= 2'd1;
                            13: env_shift_p2 <= {1'b0, rate_lo_p1[1]};
                            14: env_shift_p2 <= {1'b0, rate_lo_p1[0]};
                            default: env_shift_p2 <= '0;
                        endcase
                    end
                end else if (env_shift_pre_p1[ENV_SHIFT_WIDTH]) begin
                    env_shift_p2 <= 2'd3;      // Saturate.
                end else if (env_shift_pre_p1 == '0) begin
                    env_shift_p2 <= {1'b0, eg_state};
                end else begin
                    env_shift_p2 <= env_shift_pre_p1[ENV_SHIFT_WIDTH-1:0];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Global envelope timer, one tick per sample after the last slot.
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            eg_timer <= '0;
            eg_timerrem <= 1'b0;
            eg_state <= 1'b0;
            eg_add <= '0;
            step_cnt <= '0;
        end else if (en_p[3] && bank_p[3] == '1
                     && op_p[3] == OP_NUM_WIDTH'(NUM_OPS_PER_BANK - 1)) begin
            eg_add <= lowest_set_pos(eg_timer); // Taken from the timer before it moves.
            if (eg_timerrem || eg_state) begin
                if (eg_timer == '1) begin
                    eg_timer <= '0;
                    eg_timerrem <= 1'b1;
                end else begin
                    eg_timer <= eg_timer + 1'b1;
                    eg_timerrem <= 1'b0;
                end
            end
            eg_state <= !eg_state;
            step_cnt <= step_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/env_level_store.sv */
`default_nettype none

// Attenuation level per slot. The step from the rate counter is applied
// when the slot reaches stage 2.
module env_level_store
    import opl3_pkg::*;
(
    input wire clk,
    input wire reset,
    input wire sample_clk_en,
    input wire [SLOT_WIDTH-1:0] slot_p0,
    input wire [ENV_SHIFT_WIDTH-1:0] env_shift_p2,
    input wire wr_en,
    input wire slot_write_t wr,
    input wire [SLOT_WIDTH-1:0] rd_slot,
    output logic [ENV_LEVEL_WIDTH-1:0] rd_level
);

    logic [ENV_LEVEL_WIDTH-1:0] levels [NUM_SLOTS];
    logic en_p [1:2];
    logic [SLOT_WIDTH-1:0] slot_p [1:2];
    logic [ENV_LEVEL_WIDTH:0] sum_p2;          // Carry bit flags overflow.
    logic [ENV_LEVEL_WIDTH-1:0] next_level_p2;

    pipeline_sr #(.ENDING_CYCLE(2)) en_sr (
        .clk,
        .in(sample_clk_en),
        .out(en_p)
    );

    pipeline_sr #(
        .payload_t(logic [SLOT_WIDTH-1:0]),
        .ENDING_CYCLE(2)
    ) slot_sr (
        .clk,
        .in(slot_p0),
        .out(slot_p)
    );

    always_comb begin
        sum_p2 = {1'b0, levels[slot_p[2]]} + (ENV_LEVEL_WIDTH + 1)'(env_shift_p2);
        next_level_p2 = sum_p2[ENV_LEVEL_WIDTH] ? ENV_LEVEL_WIDTH'(ENV_LEVEL_MAX)
                                                : sum_p2[ENV_LEVEL_WIDTH-1:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                levels[i] <= '0;
            end
            rd_level <= '0;
        end else begin
            if (en_p[2])
                levels[slot_p[2]] <= next_level_p2;
            if (wr_en)
                levels[wr.slot] <= '0;         // Later assignment, so the write wins.
            rd_level <= levels[rd_slot];       // Registered host read.
        end
    end

endmodule

`default_nettype wire

/* verilog/env_rate_top.sv */
`default_nettype none

module env_rate_top
    import opl3_pkg::*;
#(
    parameter int CLKS_PER_SAMPLE = 40
) (
    input wire clk,
    input wire reset,
    input wire wr_en,
    input wire slot_write_t wr,
    input wire [SLOT_WIDTH-1:0] rd_slot,
    output logic [ENV_LEVEL_WIDTH-1:0] rd_level
);

    logic sample_clk_en;
    logic [BANK_NUM_WIDTH-1:0] bank_num;
    logic [OP_NUM_WIDTH-1:0] op_num;
    logic [SLOT_WIDTH-1:0] slot_p0;
    op_env_params_t params;
    logic [ENV_SHIFT_WIDTH-1:0] env_shift_p2;

    // Flat slot index, bank 1 follows the 18 operators of bank 0.
    assign slot_p0 = bank_num != '0 ? SLOT_WIDTH'(op_num + NUM_OPS_PER_BANK)
                                    : SLOT_WIDTH'(op_num);

    op_sequencer #(.CLKS_PER_SAMPLE(CLKS_PER_SAMPLE)) sequencer (
        .clk, .reset, .sample_clk_en, .bank_num, .op_num
    );

    op_param_ram param_ram (
        .clk, .reset, .wr_en, .wr, .rd_slot(slot_p0), .params
    );

    // The effective rate is only watched by the assertions.
    env_rate_counter rate_counter (
        .clk, .reset, .sample_clk_en, .bank_num, .op_num, .params,
        .rate_hi_p2(), .env_shift_p2
    );

    env_level_store level_store (
        .clk, .reset, .sample_clk_en, .slot_p0, .env_shift_p2,
        .wr_en, .wr, .rd_slot, .rd_level
    );

endmodule

`default_nettype wire

/* sim/env_rate_props.sv */
`default_nettype none

// Checks on the rate counter outputs, bound into every env_rate_counter.
module env_rate_props
    import opl3_pkg::*;
(
    input wire clk,
    input wire reset,
    input wire op_env_params_t params,
    input wire [REG_ENV_WIDTH:0] rate_hi_p2,
    input wire [ENV_SHIFT_WIDTH-1:0] env_shift_p2
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;                        // Number of assertion failures so far.

    // The step never goes past 3, and it is bounded by the effective rate.
    // Slow rates step by at most one, rate 13 by at most two.
    shift_in_range: assert property (@(posedge clk) disable iff (reset)
        env_shift_p2 <= ((rate_hi_p2 < 12) ? 1 : rate_hi_p2 - 11))
        else begin
            $error("env_shift_p2 is too large for its effective rate.");
            fail_count++;
        end

    // The effective rate is clamped.
    rate_clamped: assert property (@(posedge clk) disable iff (reset)
        rate_hi_p2 <= 15)
        else begin
            $error("rate_hi_p2 is above 15.");
            fail_count++;
        end

    // A requested rate of zero gives no step two cycles later.
    zero_rate_no_step: assert property (@(posedge clk) disable iff (reset)
        params.rate == '0 |-> ##2 env_shift_p2 == '0)
        else begin
            $error("Nonzero step for a slot with rate 0.");
            fail_count++;
        end

endmodule

bind env_rate_counter env_rate_props props_i (
    .clk, .reset, .params, .rate_hi_p2, .env_shift_p2
);

`default_nettype wire

/* sim/env_rate_tb.sv */
`default_nettype none

module env_rate_tb
    import opl3_pkg::*;
#(
    parameter int CLKS_PER_SAMPLE = 40
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS = 38;

    // One table row: the host write and the number of samples to run after it.
    typedef struct packed {
        slot_write_t wr;
        logic [15:0] samples;
    } stim_row_t;

    logic clk;
    logic reset;
    logic wr_en;
    slot_write_t wr;
    logic [SLOT_WIDTH-1:0] rd_slot;
    logic [ENV_LEVEL_WIDTH-1:0] rd_level;

    stim_row_t rows [NUM_ROWS];
    int edge_cnt;                              // Rising edges since reset was released.
    int cycle_cnt;                             // All rising edges, for the timeout.
    int cycle_limit;
    op_env_params_t m_params [NUM_SLOTS];      // Model copy of the parameter RAM.
    int m_level [NUM_SLOTS];                   // Model copy of the levels.
    int m_timer, m_rem, m_state, m_add, m_step, m_samples;

    env_rate_top #(.CLKS_PER_SAMPLE(CLKS_PER_SAMPLE)) dut_i (
        .clk, .reset, .wr_en, .wr, .rd_slot, .rd_level
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                // 100 ns period.
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!reset)
            edge_cnt <= edge_cnt + 1;          // Slot walk phase is fixed to this count.
    end

    always @(negedge clk) begin
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: the run went past %0d clock cycles.", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "Run stopped by the cycle limit.");
        end else if (dut_i.rate_counter.props_i.fail_count != 0) begin
            $display("A concurrent assertion in the rate counter failed.");
            $display("STATUS: FAIL");
            $fatal(1, "Run stopped by an assertion failure.");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model of the envelope step and the global timer.
    //////////////////////////////////////////////////////////////////////
    function automatic int low_bit_pos(input int t);
        for (int i = 0; i < 13; i++)
            if (t[i])
                return i + 1;                  // Position counted from one.
        return 0;
    endfunction

    function automatic int step_for(input op_env_params_t p);
        int ksv, ks, rate, hi, lo, inc, pre, pos;
        if (p.rate == 0)
            return 0;
        ksv = 2 * p.block + (p.nts ? p.fnum[8] : p.fnum[9]);
        ks = p.ksr ? ksv : ksv / 4;
        rate = ks + 4 * p.rate;
        hi = (rate / 4 > 15) ? 15 : rate / 4;  // Clamp the effective rate.
        lo = rate % 4;
        if (hi < 12) begin
            if (m_state == 0)
                return 0;                      // Slow rates skip alternate samples.
            pos = hi + m_add;
            if (pos == 12)
                return 1;
            if (pos == 13)
                return lo / 2;
            if (pos == 14)
                return lo % 2;
            return 0;
        end
        inc = (lo == 1 && m_step == 3) || (lo == 2 && m_step % 2 == 1)
              || (lo == 3 && m_step != 0);
        pre = hi % 4 + inc;
        if (pre > 3)
            return 3;
        if (pre == 0)
            return m_state;
        return pre;
    endfunction

    task automatic run_model_sample();
        int lvl;
        int add_next;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            lvl = m_level[s] + step_for(m_params[s]);
            m_level[s] = (lvl > ENV_LEVEL_MAX) ? ENV_LEVEL_MAX : lvl;
        end
        // The timer moves only after every slot has seen the old state.
        add_next = low_bit_pos(m_timer);
        if (m_rem != 0 || m_state != 0) begin
            if (m_timer == 8191) begin
                m_timer = 0;
                m_rem = 1;
            end else begin
                m_timer = m_timer + 1;
                m_rem = 0;
            end
        end
        m_add = add_next;
        m_state = 1 - m_state;
        m_step = (m_step + 1) % 4;
        m_samples++;
    endtask

    task automatic advance_model(input int samples);
        while (m_samples < samples)
            run_model_sample();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus table and helpers.
    //////////////////////////////////////////////////////////////////////
    function automatic stim_row_t make_row(input int slot, input int ksr, input int nts,
                                           input int fnum, input int block, input int rate,
                                           input int samples);
        stim_row_t r;
        r.wr.slot = SLOT_WIDTH'(slot);
        r.wr.params.ksr = ksr[0];
        r.wr.params.nts = nts[0];
        r.wr.params.fnum = REG_FNUM_WIDTH'(fnum);
        r.wr.params.block = REG_BLOCK_WIDTH'(block);
        r.wr.params.rate = REG_ENV_WIDTH'(rate);
        r.samples = 16'(samples);
        return r;
    endfunction

    task automatic build_table();
        rows[0] = make_row(0, 1, 1, 'h3ff, 7, 0, 3); // Rate 0 with maximal key scaling.
        rows[1] = make_row(1, 1, 0, 'h200, 7, 12, 0);
        rows[2] = make_row(2, 1, 1, 'h100, 6, 13, 0);
        rows[3] = make_row(3, 1, 0, 'h3ff, 7, 14, 0);
        rows[4] = make_row(4, 1, 0, 'h000, 5, 15, 0);
        // Low rates 1 to 11, key scaling adds at most 3.
        for (int r = 1; r <= 11; r++)
            rows[4 + r] = make_row(4 + r, 0, r % 2, 'h2aa, r % 8, r, 0);
        // The last random row runs until the timer has passed 256, where slot 0 would step.
        for (int s = 16; s < NUM_SLOTS; s++)
            rows[s] = make_row(s, $urandom % 2, s % 2, $urandom % 1024, $urandom % 8,
                               1 + s % 15, (s == NUM_SLOTS - 1) ? 600 : 0);
        rows[36] = make_row(3, 1, 0, 'h000, 7, 14, 2); // Rewrite, neighbours keep levels.
        rows[37] = make_row(20, 0, 1, 'h3ff, 7, 0, 1);
    endtask

    task automatic wait_for_edge(input int target);
        do
            @(negedge clk);
        while (edge_cnt != target);
    endtask

    task automatic compare_values(input int got, input int expected, input string what);
        if (got != expected) begin
            $display("[ERROR] %0d ns: %s read %0d, expected %0d.", $time, what, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Level mismatch.");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence.
    //////////////////////////////////////////////////////////////////////
    initial begin
        int total_samples;
        int target;
        stim_row_t row;
        void'($urandom(32'he027));
        reset = 1'b1;
        wr_en = 1'b0;
        wr = '0;
        rd_slot = '0;
        edge_cnt = 0;
        cycle_cnt = 0;
        m_timer = 0;
        m_rem = 0;
        m_state = 0;
        m_add = 0;
        m_step = 0;
        m_samples = 0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            m_params[s] = '0;
            m_level[s] = 0;
        end
        build_table();
        total_samples = 0;
        foreach (rows[i])
            total_samples += rows[i].samples + 2; // Write period and read period.
        cycle_limit = (total_samples + 4) * CLKS_PER_SAMPLE + 20;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        foreach (rows[i]) begin
            row = rows[i];
            // Writes land on the first edge of a sample, ahead of slot 0.
            wait_for_edge((edge_cnt / CLKS_PER_SAMPLE + 1) * CLKS_PER_SAMPLE);
            advance_model(edge_cnt / CLKS_PER_SAMPLE);
            m_params[row.wr.slot] = row.wr.params;
            m_level[row.wr.slot] = 0;
            wr_en = 1'b1;
            wr = row.wr;
            @(negedge clk);
            wr_en = 1'b0;
            if (row.samples != 0) begin
                target = edge_cnt - 1 + row.samples * CLKS_PER_SAMPLE;
                wait_for_edge(target);
                advance_model(target / CLKS_PER_SAMPLE);
                // Reads stay ahead of the stage 2 updates of this sample.
                for (int s = 0; s < NUM_SLOTS; s++) begin
                    rd_slot = SLOT_WIDTH'(s);
                    @(negedge clk);
                    compare_values(rd_level, m_level[s], $sformatf("row %0d slot %0d", i, s));
                end
            end
        end
        if (dut_i.rate_counter.props_i.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Concurrent assertions failed during the run.");
            $display("STATUS: FAIL");
            $fatal(1, "Assertion failures.");
        end
    end

endmodule

`default_nettype wire

/* build.f */
verilog/opl3_pkg.sv
verilog/pipeline_sr.sv
verilog/op_sequencer.sv
verilog/op_param_ram.sv
verilog/env_rate_counter.sv
verilog/env_level_store.sv
verilog/env_rate_top.sv
sim/env_rate_props.sv
sim/env_rate_tb.sv
